// File: Bender.yml
package:
  name: i2c_eeprom

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/eeprom_pkg.sv
      - hw/i2c_line_monitor.sv
      - hw/bit_counter.sv
      - hw/byte_shifter.sv
      - hw/eeprom_array.sv
      - hw/eeprom_fsm.sv
      - hw/i2c_eeprom.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_i2c_eeprom.sv

// File: hw/bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_counter import eeprom_pkg::*;
(
    input  logic     sda,
    input  logic     rst_n,
    input  bus_evt_t evt,
    input  logic     clear,
    output bit_idx_t bit_idx,
    output logic     byte_done,
    output logic     ack_slot,
    output logic     frame_end
);

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            bit_idx   <= '0;
            byte_done <= 1'b0;
            ack_slot  <= 1'b0;
            frame_end <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            frame_end <= 1'b0;
            if (clear || evt.start)
            begin
                bit_idx  <= '0;
                ack_slot <= 1'b0;
            end
            else if (evt.scl_rise)
            begin
                // eighth bit sampled here
                if (bit_idx == 4'd7)
                    byte_done <= 1'b1;
                // holds at 8 through the ack bit
                if (bit_idx != 4'd8)
                    bit_idx <= bit_idx + 4'd1;
            end
            else if (evt.scl_fall)
            begin
                if (ack_slot)
                begin
                    ack_slot  <= 1'b0;
                    frame_end <= 1'b1;
                    bit_idx   <= '0;
                end
                else if (bit_idx == 4'd8)
                begin
                    ack_slot <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module byte_shifter import eeprom_pkg::*;
(
    input  logic     sda,
    input  logic     rst_n,
    input  bus_evt_t evt,
    input  logic     load,
    input  byte_t    load_data,
    input  logic     shift_out,
    output byte_t    rx_byte,
    output logic     tx_bit
);

    byte_t shreg;

    assign rx_byte = shreg;

    // msb first in both directions
    always_ff @(posedge sda)
    begin
        if (load)
        begin
            shreg <= load_data;
        end
        else if (evt.scl_rise)
        begin
            shreg <= {shreg[6:0], evt.data_level};
        end
    end

    // next bit goes out while scl is low, the rise then moves
    // the following bit to the top of the register
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            tx_bit <= 1'b1;
        end
        else if (evt.scl_fall && shift_out)
        begin
            tx_bit <= shreg[7];
        end
    end

endmodule

`default_nettype wire

// File: hw/eeprom_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module eeprom_array import eeprom_pkg::*;
(
    input  logic      sda,
    input  logic      we,
    input  mem_addr_t addr,
    input  byte_t     wdata,
    output byte_t     rdata,
    input  logic      rst_n
);

    byte_t mem [`EEPROM_DEPTH];

    // read sees the old byte when written in the same cycle
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `EEPROM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end
        else
        begin
            if (we)
            begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// number of bytes in the array
`define EEPROM_DEPTH 2048

// full address, block bits plus word address
`define EEPROM_AW 11

// upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// flops per bus input
`define EEPROM_SYNC_STAGES 2

`endif

// File: hw/eeprom_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module eeprom_fsm import eeprom_pkg::*;
(
    input  logic      sda,
    input  logic      rst_n,
    input  bus_evt_t  evt,
    input  bit_idx_t  bit_idx,
    input  logic      byte_done,
    input  logic      ack_slot,
    input  logic      frame_end,
    input  byte_t     rx_byte,
    input  logic      tx_bit,
    input  byte_t     rdata,
    output logic      clear,
    output logic      load,
    output logic      shift_out,
    output logic      mem_we,
    output mem_addr_t mem_addr,
    output byte_t     mem_wdata,
    output logic      sda_oe
);

    ctrl_state_e state;
    ctrl_state_e ack_next;
    block_sel_t  blk;
    mem_addr_t   ptr;
    logic        fetch;
    logic        wr_go;
    logic        ack_rise;
    logic        drive_tx;

    // scl rise inside the ack slot
    assign ack_rise = evt.scl_rise && ack_slot;

    assign mem_addr  = ptr;
    assign mem_wdata = rx_byte;

    // rdata follows ptr, so an unchanged byte is not rewritten
    assign mem_we = wr_go && (rx_byte != rdata);

    assign shift_out = (state == RDATA) || (state == ACK_IN) ||
                       (state == ACK_OUT && ack_next == RDATA);

    // released from the ack slot on, master owns the line then
    assign drive_tx = (state == RDATA);
    assign sda_oe   = drive_tx ? (!tx_bit && !ack_slot) : (state == ACK_OUT && ack_slot);

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            ack_next <= IDLE;
            blk      <= '0;
            ptr      <= '0;
            fetch    <= 1'b0;
            load     <= 1'b0;
            wr_go    <= 1'b0;
            clear    <= 1'b0;
        end
        else
        begin
            fetch <= 1'b0;
            wr_go <= 1'b0;
            clear <= 1'b0;
            // rdata is valid the cycle after fetch
            load  <= fetch;
            if (load || wr_go)
                ptr <= ptr + 1'b1;

            if (evt.stop)
            begin
                state <= IDLE;
                clear <= 1'b1;
            end
            else if (evt.start)
            begin
                state <= CTRL;
            end
            else
            begin
                case (state)
                    CTRL:
                    begin
                        // drop out early once the device code is in
                        if (bit_idx == 4'd4 && rx_byte[3:0] != `EEPROM_DEV_CODE)
                        begin
                            state <= IDLE;
                        end
                        else if (byte_done)
                        begin
                            blk   <= rx_byte[3:1];
                            state <= ACK_OUT;
                            if (rx_byte[0])
                            begin
                                ptr      <= {rx_byte[3:1], ptr[7:0]};
                                ack_next <= RDATA;
                            end
                            else
                            begin
                                ack_next <= ADDR;
                            end
                        end
                    end
                    ADDR:
                    begin
                        if (byte_done)
                        begin
                            ptr      <= {blk, rx_byte};
                            ack_next <= WDATA;
                            state    <= ACK_OUT;
                        end
                    end
                    WDATA:
                    begin
                        // single byte write, anything after it is ignored
                        if (byte_done)
                        begin
                            wr_go    <= 1'b1;
                            ack_next <= WAIT_STOP;
                            state    <= ACK_OUT;
                        end
                    end
                    ACK_OUT:
                    begin
                        if (ack_rise && ack_next == RDATA)
                            fetch <= 1'b1;
                        if (frame_end)
                            state <= ack_next;
                    end
                    RDATA:
                    begin
                        if (ack_slot)
                            state <= ACK_IN;
                    end
                    ACK_IN:
                    begin
                        if (ack_rise)
                        begin
                            // master nack ends the read
                            if (evt.data_level)
                            begin
                                state <= WAIT_STOP;
                                clear <= 1'b1;
                            end
                            else
                            begin
                                fetch <= 1'b1;
                            end
                        end
                        else if (frame_end)
                        begin
                            state <= RDATA;
                        end
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/eeprom_pkg.sv
`default_nettype none

`include "eeprom_config.svh"

package eeprom_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [`EEPROM_AW-1:0] mem_addr_t;

    // block bits 3:1 of the control byte
    typedef logic [2:0] block_sel_t;

    // slot 0 to 8, 8 is the ack slot
    typedef logic [3:0] bit_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        CTRL,
        ADDR,
        WDATA,
        RDATA,
        ACK_OUT,
        ACK_IN,
        WAIT_STOP
    } ctrl_state_e;

    // one-cycle strobes plus the synchronized data level
    typedef struct packed {
        logic start;
        logic stop;
        logic scl_rise;
        logic scl_fall;
        logic data_level;
    } bus_evt_t;

endpackage

`default_nettype wire

// File: hw/i2c_eeprom.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom import eeprom_pkg::*;
(
    input  logic sda,
    input  logic rst_n,
    input  logic i2c_scl,
    input  logic i2c_data,
    output logic i2c_data_oe
);

    bus_evt_t  evt;
    bit_idx_t  bit_idx;
    logic      byte_done;
    logic      ack_slot;
    logic      frame_end;
    logic      clear;
    logic      load;
    logic      shift_out;
    byte_t     rx_byte;
    logic      tx_bit;
    byte_t     rdata;
    logic      mem_we;
    mem_addr_t mem_addr;
    byte_t     mem_wdata;

    i2c_line_monitor u_monitor (
        .sda      (sda),
        .rst_n    (rst_n),
        .i2c_scl  (i2c_scl),
        .i2c_data (i2c_data),
        .evt      (evt)
    );

    bit_counter u_counter (
        .sda       (sda),
        .rst_n     (rst_n),
        .evt       (evt),
        .clear     (clear),
        .bit_idx   (bit_idx),
        .byte_done (byte_done),
        .ack_slot  (ack_slot),
        .frame_end (frame_end)
    );

    // read bytes are loaded straight from the array port
    byte_shifter u_shifter (
        .sda       (sda),
        .rst_n     (rst_n),
        .evt       (evt),
        .load      (load),
        .load_data (rdata),
        .shift_out (shift_out),
        .rx_byte   (rx_byte),
        .tx_bit    (tx_bit)
    );

    eeprom_array u_array (
        .sda   (sda),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (rdata),
        .rst_n (rst_n)
    );

    eeprom_fsm u_fsm (
        .sda       (sda),
        .rst_n     (rst_n),
        .evt       (evt),
        .bit_idx   (bit_idx),
        .byte_done (byte_done),
        .ack_slot  (ack_slot),
        .frame_end (frame_end),
        .rx_byte   (rx_byte),
        .tx_bit    (tx_bit),
        .rdata     (rdata),
        .clear     (clear),
        .load      (load),
        .shift_out (shift_out),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .sda_oe    (i2c_data_oe)
    );

endmodule

`default_nettype wire

// File: hw/i2c_line_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module i2c_line_monitor import eeprom_pkg::*;
(
    input  logic     sda,
    input  logic     rst_n,
    input  logic     i2c_scl,
    input  logic     i2c_data,
    output bus_evt_t evt
);

    localparam int STAGES = `EEPROM_SYNC_STAGES;

    logic [STAGES-1:0] scl_sync;
    logic [STAGES-1:0] data_sync;
    logic              scl_s;
    logic              data_s;
    logic              scl_prev;
    logic              data_prev;
    bus_evt_t          evt_next;

    assign scl_s  = scl_sync[STAGES-1];
    assign data_s = data_sync[STAGES-1];

    // idle bus is high on both lines
    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_sync  <= '1;
            data_sync <= '1;
            scl_prev  <= 1'b1;
            data_prev <= 1'b1;
        end
        else
        begin
            scl_sync  <= {scl_sync[STAGES-2:0], i2c_scl};
            data_sync <= {data_sync[STAGES-2:0], i2c_data};
            scl_prev  <= scl_s;
            data_prev <= data_s;
        end
    end

    // data changes while scl stays high mark start and stop
    always_comb
    begin
        evt_next.start      = scl_s && scl_prev && data_prev && !data_s;
        evt_next.stop       = scl_s && scl_prev && !data_prev && data_s;
        evt_next.scl_rise   = scl_s && !scl_prev;
        evt_next.scl_fall   = !scl_s && scl_prev;
        evt_next.data_level = data_s;
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            evt <= '{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0,
                     data_level: 1'b1};
        end
        else
        begin
            evt <= evt_next;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/eeprom_pkg.sv
hw/i2c_line_monitor.sv
hw/bit_counter.sv
hw/byte_shifter.sv
hw/eeprom_array.sv
hw/eeprom_fsm.sv
hw/i2c_eeprom.sv
test/tb_i2c_eeprom.sv

// File: test/tb_i2c_eeprom.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module tb_i2c_eeprom import eeprom_pkg::*;
();

    localparam int BIT_CYCLES = 16;
    localparam int SEQ_LEN    = 6;
    // bus bit times per transaction, start and stop take one each
    localparam int WR_BITS    = 1 + 3 * 9 + 1;
    localparam int RD_BITS    = 1 + 2 * 9 + 1 + 9 + 9 + 1;
    localparam int SEQ_BITS   = 1 + 2 * 9 + 1 + 9 + SEQ_LEN * 9 + 1;
    localparam int CUT_BITS   = 1 + 2 * 9 + 4 + 1;
    localparam int TOTAL_BITS = 20 + 20 * (WR_BITS + RD_BITS) + (2 * WR_BITS + RD_BITS)
                              + (SEQ_LEN * WR_BITS + SEQ_BITS + 2)
                              + 8 * (WR_BITS + RD_BITS) + (WR_BITS + CUT_BITS + RD_BITS);
    localparam int TIMEOUT_CYCLES = TOTAL_BITS * BIT_CYCLES * 2;

    typedef struct packed {
        logic      is_ack;
        byte_t     ctrl;
        mem_addr_t addr;
        byte_t     got;
    } check_t;

    logic        sda;
    logic        rst_n;
    logic        i2c_scl;
    logic        i2c_data;
    logic        i2c_data_oe;
    logic        master_pull;
    byte_t       ref_mem [`EEPROM_DEPTH];
    check_t      check_q [$];
    logic [31:0] lfsr_state = 32'h357e;
    int          checks = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          cycle_cnt = 0;

    i2c_eeprom dut (
        .sda         (sda),
        .rst_n       (rst_n),
        .i2c_scl     (i2c_scl),
        .i2c_data    (i2c_data),
        .i2c_data_oe (i2c_data_oe)
    );

    // wired-AND with a pull-up
    assign i2c_data = !(master_pull || (i2c_data_oe === 1'b1));

    initial sda = 1'b0;
    always #10 sda = ~sda;

    always @(posedge sda)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // slave acks any byte of a transaction whose device code matches
    function automatic byte_t expected_value(input check_t c);
        if (c.is_ack)
            return (c.ctrl[7:4] == `EEPROM_DEV_CODE) ? 8'h00 : 8'h01;
        else
            return ref_mem[c.addr];
    endfunction

    task automatic ref_write(input byte_t ctrl, input byte_t word, input byte_t data);
        if (ctrl[7:4] == `EEPROM_DEV_CODE && !ctrl[0])
            ref_mem[{ctrl[3:1], word}] = data;
    endtask

    always @(posedge sda)
    begin
        check_t c;
        byte_t  exp;
        while (check_q.size() > 0)
        begin
            c   = check_q.pop_front();
            exp = expected_value(c);
            checks++;
            if (c.got !== exp)
            begin
                errors++;
                $display("MISMATCH at %0t: %s addr %0d ctrl %02h got %02h expected %02h",
                         $time, c.is_ack ? "ack" : "read", c.addr, c.ctrl, c.got, exp);
            end
        end
    end

    task automatic push_check(input logic is_ack, input byte_t ctrl, input mem_addr_t addr,
                              input byte_t got);
        check_q.push_back('{is_ack: is_ack, ctrl: ctrl, addr: addr, got: got});
    endtask

    task automatic check_oe_low();
        checks++;
        if (i2c_data_oe !== 1'b0)
        begin
            errors++;
            $display("MISMATCH at %0t: i2c_data_oe high on an idle bus", $time);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sda);
        #2;
    endtask

    // 8 sda cycles low, 8 high, sample mid high
    task automatic clock_bit(input logic b, output logic sampled);
        i2c_scl = 1'b0;
        wait_cycles(4);
        master_pull = !b;
        wait_cycles(4);
        i2c_scl = 1'b1;
        wait_cycles(4);
        sampled = i2c_data;
        wait_cycles(4);
    endtask

    // also serves as repeated start
    task automatic start_condition();
        i2c_scl = 1'b0;
        wait_cycles(4);
        master_pull = 1'b0;
        wait_cycles(4);
        i2c_scl = 1'b1;
        wait_cycles(4);
        master_pull = 1'b1;
        wait_cycles(4);
    endtask

    task automatic stop_condition();
        i2c_scl = 1'b0;
        wait_cycles(4);
        master_pull = 1'b1;
        wait_cycles(4);
        i2c_scl = 1'b1;
        wait_cycles(4);
        master_pull = 1'b0;
        wait_cycles(4);
    endtask

    task automatic send_byte(input byte_t b, output logic ack_level);
        logic s;
        for (int i = 7; i >= 0; i--)
            clock_bit(b[i], s);
        clock_bit(1'b1, ack_level);
    endtask

    task automatic read_byte(input logic give_ack, output byte_t d);
        logic s;
        d = '0;
        repeat (8)
        begin
            clock_bit(1'b1, s);
            d = {d[6:0], s};
        end
        clock_bit(!give_ack, s);
    endtask

    task automatic write_txn(input byte_t ctrl, input byte_t word, input byte_t data);
        logic ack;
        start_condition();
        send_byte(ctrl, ack);
        push_check(1'b1, ctrl, {ctrl[3:1], word}, {7'b0, ack});
        send_byte(word, ack);
        push_check(1'b1, ctrl, {ctrl[3:1], word}, {7'b0, ack});
        send_byte(data, ack);
        push_check(1'b1, ctrl, {ctrl[3:1], word}, {7'b0, ack});
        stop_condition();
        ref_write(ctrl, word, data);
    endtask

    // dummy write, repeated start, then n bytes with a nack on the last
    task automatic read_txn(input mem_addr_t a, input int n);
        byte_t     ctrl_w;
        byte_t     ctrl_r;
        logic      ack;
        byte_t     d;
        mem_addr_t ai;
        ctrl_w = {`EEPROM_DEV_CODE, a[10:8], 1'b0};
        ctrl_r = {`EEPROM_DEV_CODE, a[10:8], 1'b1};
        ai     = a;
        start_condition();
        send_byte(ctrl_w, ack);
        push_check(1'b1, ctrl_w, a, {7'b0, ack});
        send_byte(a[7:0], ack);
        push_check(1'b1, ctrl_w, a, {7'b0, ack});
        start_condition();
        send_byte(ctrl_r, ack);
        push_check(1'b1, ctrl_r, a, {7'b0, ack});
        for (int i = 0; i < n; i++)
        begin
            read_byte(i != n - 1, d);
            push_check(1'b0, ctrl_r, ai, d);
            ai = ai + 1'b1;
        end
        stop_condition();
    endtask

    // stop after four data bits
    task automatic cut_write(input mem_addr_t a, input byte_t data);
        byte_t ctrl;
        logic  ack;
        logic  s;
        ctrl = {`EEPROM_DEV_CODE, a[10:8], 1'b0};
        start_condition();
        send_byte(ctrl, ack);
        push_check(1'b1, ctrl, a, {7'b0, ack});
        send_byte(a[7:0], ack);
        push_check(1'b1, ctrl, a, {7'b0, ack});
        for (int i = 7; i >= 4; i--)
            clock_bit(data[i], s);
        stop_condition();
    endtask

    task automatic end_test(input int num, input string name, input int errs_at);
        int errs;
        @(posedge sda);
        #2;
        errs = errors - errs_at;
        if (errs != 0)
            failed_tests++;
        $display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "ok" : "FAIL", errs);
    endtask

    initial
    begin
        int          errs_at;
        logic [31:0] r;
        mem_addr_t   a;
        byte_t       word;
        byte_t       d;
        rst_n       = 1'b0;
        i2c_scl     = 1'b1;
        master_pull = 1'b0;
        for (int i = 0; i < `EEPROM_DEPTH; i++)
            ref_mem[i] = '0;
        repeat (8) @(posedge sda);
        #2;
        rst_n = 1'b1;

        errs_at = errors;
        repeat (20 * BIT_CYCLES)
        begin
            wait_cycles(1);
            check_oe_low();
        end
        end_test(1, "idle after reset", errs_at);

        errs_at = errors;
        repeat (20)
        begin
            take_bits(11, r);
            a = r[10:0];
            take_bits(8, r);
            write_txn({`EEPROM_DEV_CODE, a[10:8], 1'b0}, a[7:0], r[7:0]);
            read_txn(a, 1);
        end
        end_test(2, "byte write and random read", errs_at);

        errs_at = errors;
        take_bits(11, r);
        a = r[10:0];
        take_bits(8, r);
        d = r[7:0];
        write_txn({`EEPROM_DEV_CODE, a[10:8], 1'b0}, a[7:0], d);
        write_txn({4'b1110, a[10:8], 1'b0}, a[7:0], ~d);
        read_txn(a, 1);
        end_test(3, "wrong device code", errs_at);

        errs_at = errors;
        a = 11'd2045;
        repeat (SEQ_LEN)
        begin
            take_bits(8, r);
            write_txn({`EEPROM_DEV_CODE, a[10:8], 1'b0}, a[7:0], r[7:0]);
            a = a + 1'b1;
        end
        read_txn(11'd2045, SEQ_LEN);
        repeat (2 * BIT_CYCLES)
        begin
            wait_cycles(1);
            check_oe_low();
        end
        end_test(4, "sequential read across the wrap", errs_at);

        errs_at = errors;
        take_bits(8, r);
        word = r[7:0];
        for (int b = 0; b < 8; b++)
        begin
            take_bits(8, r);
            write_txn({`EEPROM_DEV_CODE, 3'(b), 1'b0}, word, r[7:0]);
        end
        for (int b = 0; b < 8; b++)
            read_txn({3'(b), word}, 1);
        end_test(5, "block select bits", errs_at);

        errs_at = errors;
        take_bits(11, r);
        a = r[10:0];
        take_bits(8, r);
        d = r[7:0];
        write_txn({`EEPROM_DEV_CODE, a[10:8], 1'b0}, a[7:0], d);
        cut_write(a, ~d);
        read_txn(a, 1);
        end_test(6, "interrupted write", errs_at);

        $display("checks: %0d, errors: %0d, failing tests: %0d", checks, errors, failed_tests);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
